//--- src/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter import cache_axi_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,
    // instruction cache read
    input  cache_ar_t i_i_ar,
    input  logic      i_i_arvalid,
    output logic      o_i_arready,
    output cache_r_t  o_i_r,
    output logic      o_i_rvalid,
    input  logic      i_i_rready,
    // data cache read
    input  cache_ar_t i_d_ar,
    input  logic      i_d_arvalid,
    output logic      o_d_arready,
    output cache_r_t  o_d_r,
    output logic      o_d_rvalid,
    input  logic      i_d_rready,
    // data cache write
    input  axi_aw_t   i_d_aw,
    input  logic      i_d_awvalid,
    output logic      o_d_awready,
    input  axi_w_t    i_d_w,
    input  logic      i_d_wvalid,
    output logic      o_d_wready,
    output logic      o_d_bvalid,
    input  logic      i_d_bready,
    // shared read port
    output axi_ar_t   o_ar,
    output logic      o_arvalid,
    input  logic      i_arready,
    input  axi_r_t    i_r,
    input  logic      i_rvalid,
    output logic      o_rready,
    // shared write port
    output axi_aw_t   o_aw,
    output logic      o_awvalid,
    input  logic      i_awready,
    output axi_w_t    o_w,
    output logic      o_wvalid,
    input  logic      i_wready,
    input  logic      i_bvalid,
    output logic      o_bready
);

    grant_state_e state;
    logic         grant_q;
    // 0 selects instruction cache, 1 data cache
    logic         sel;

    always_comb begin
        if (state == grant_held) begin
            sel = grant_q;
        end else begin
            sel = !i_i_arvalid && i_d_arvalid;
        end
    end

    always_comb begin
        if (sel) begin
            o_ar      = '{id: ID_DATA, addr: i_d_ar.addr, len: i_d_ar.len};
            o_arvalid = i_d_arvalid;
        end else begin
            o_ar      = '{id: ID_INST, addr: i_i_ar.addr, len: i_i_ar.len};
            o_arvalid = i_i_arvalid;
        end
    end

    assign o_i_arready = i_arready && !sel;
    assign o_d_arready = i_arready && sel;

    // hold the winner until its address is taken
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state   <= grant_free;
            grant_q <= 1'b0;
        end else begin
            case (state)
                grant_free: begin
                    if (o_arvalid && !i_arready) begin
                        state   <= grant_held;
                        grant_q <= sel;
                    end
                end
                grant_held: begin
                    if (i_arready) begin
                        state <= grant_free;
                    end
                end
                default: state <= grant_free;
            endcase
        end
    end

    // read beats steered by id
    assign o_i_r      = '{data: i_r.data, last: i_r.last};
    assign o_d_r      = '{data: i_r.data, last: i_r.last};
    assign o_i_rvalid = i_rvalid && (i_r.id == ID_INST);
    assign o_d_rvalid = i_rvalid && (i_r.id == ID_DATA);
    assign o_rready   = (i_r.id == ID_INST) ? i_i_rready :
                        (i_r.id == ID_DATA) ? i_d_rready : 1'b0;

    // writes only come from the data cache
    assign o_aw        = i_d_aw;
    assign o_awvalid   = i_d_awvalid;
    assign o_d_awready = i_awready;
    assign o_w         = i_d_w;
    assign o_wvalid    = i_d_wvalid;
    assign o_d_wready  = i_wready;
    assign o_d_bvalid  = i_bvalid;
    assign o_bready    = i_d_bready;

    ar_hold_stable: assert property (@(posedge clk) disable iff (i_reset)
        o_arvalid && !i_arready |=> $stable(o_ar));

    r_id_known: assert property (@(posedge clk) disable iff (i_reset)
        i_rvalid |-> (i_r.id == ID_INST || i_r.id == ID_DATA));

endmodule

//--- src/axi_ram_read.sv
`timescale 1ns/1ps

module axi_ram_read import cache_axi_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic                     clk,
    input  logic                     i_reset,
    input  axi_ar_t                  i_ar,
    input  logic                     i_arvalid,
    output logic                     o_arready,
    output axi_r_t                   o_r,
    output logic                     o_rvalid,
    input  logic                     i_rready,
    output logic [RAM_ADDR_BITS-1:0] o_rd_addr,
    input  data_t                    i_rd_data
);

    rd_state_e                state;
    id_t                      id_q;
    logic [RAM_ADDR_BITS-1:0] word_q;
    // beats still to come after the current one
    len_t                     beats_left;
    logic                     last_beat;

    assign last_beat = (beats_left == '0);
    assign o_arready = (state == rd_st_idle);
    assign o_rvalid  = (state == rd_st_burst);
    assign o_rd_addr = word_q;
    assign o_r       = '{id: id_q, data: i_rd_data, last: last_beat};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= rd_st_idle;
        end else begin
            case (state)
                rd_st_idle: begin
                    if (i_arvalid) begin
                        state <= rd_st_burst;
                    end
                end
                rd_st_burst: begin
                    if (i_rready && last_beat) begin
                        state <= rd_st_idle;
                    end
                end
                default: state <= rd_st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rd_st_idle && i_arvalid) begin
            id_q       <= i_ar.id;
            word_q     <= i_ar.addr[RAM_ADDR_BITS+1:2];
            beats_left <= i_ar.len;
        end else if (state == rd_st_burst && i_rready && !last_beat) begin
            word_q     <= word_q + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
    end

    // a stalled beat keeps its word, id and last flag
    beat_held_stable: assert property (@(posedge clk) disable iff (i_reset)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rd_addr) && $stable(o_r.id)
            && $stable(o_r.last));

endmodule

//--- src/axi_ram_write.sv
`timescale 1ns/1ps

module axi_ram_write import cache_axi_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic                     clk,
    input  logic                     i_reset,
    input  axi_aw_t                  i_aw,
    input  logic                     i_awvalid,
    output logic                     o_awready,
    input  axi_w_t                   i_w,
    input  logic                     i_wvalid,
    output logic                     o_wready,
    output logic                     o_bvalid,
    input  logic                     i_bready,
    output logic                     o_we,
    output logic [RAM_ADDR_BITS-1:0] o_wr_addr,
    output data_t                    o_wr_data,
    output strb_t                    o_wr_strb
);

    wr_state_e                state;
    logic [RAM_ADDR_BITS-1:0] word_q;
    len_t                     len_q;
    // beats accepted so far in this burst
    len_t                     beat_cnt;

    assign o_awready = (state == wr_st_idle);
    assign o_wready  = (state == wr_st_data);
    assign o_bvalid  = (state == wr_st_resp);

    // each accepted beat goes straight to the bank
    assign o_we      = o_wready && i_wvalid;
    assign o_wr_addr = word_q;
    assign o_wr_data = i_w.data;
    assign o_wr_strb = i_w.strb;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= wr_st_idle;
        end else begin
            case (state)
                wr_st_idle: begin
                    if (i_awvalid) begin
                        state <= wr_st_data;
                    end
                end
                wr_st_data: begin
                    if (i_wvalid && i_w.last) begin
                        state <= wr_st_resp;
                    end
                end
                wr_st_resp: begin
                    if (i_bready) begin
                        state <= wr_st_idle;
                    end
                end
                default: state <= wr_st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wr_st_idle && i_awvalid) begin
            word_q   <= i_aw.addr[RAM_ADDR_BITS+1:2];
            len_q    <= i_aw.len;
            beat_cnt <= '0;
        end else if (o_we) begin
            word_q   <= word_q + 1'b1;
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // last must line up with the burst length from aw
    wlast_on_len: assert property (@(posedge clk) disable iff (i_reset)
        o_wready && i_wvalid |-> (i_w.last == (beat_cnt == len_q)));

endmodule

//--- src/cache_axi_pkg.sv
package cache_axi_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  len_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  id_t;

    // read ids on the shared port
    localparam id_t ID_INST = 4'd0;
    localparam id_t ID_DATA = 4'd1;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } cache_ar_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } cache_r_t;

    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } axi_ar_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef enum logic {grant_free, grant_held} grant_state_e;
    typedef enum logic {rd_st_idle, rd_st_burst} rd_state_e;
    typedef enum logic [1:0] {wr_st_idle, wr_st_data, wr_st_resp} wr_state_e;

endpackage

//--- src/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top import cache_axi_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic      clk,
    input  logic      i_reset,
    input  cache_ar_t i_i_ar,
    input  logic      i_i_arvalid,
    output logic      o_i_arready,
    output cache_r_t  o_i_r,
    output logic      o_i_rvalid,
    input  logic      i_i_rready,
    input  cache_ar_t i_d_ar,
    input  logic      i_d_arvalid,
    output logic      o_d_arready,
    output cache_r_t  o_d_r,
    output logic      o_d_rvalid,
    input  logic      i_d_rready,
    input  axi_aw_t   i_d_aw,
    input  logic      i_d_awvalid,
    output logic      o_d_awready,
    input  axi_w_t    i_d_w,
    input  logic      i_d_wvalid,
    output logic      o_d_wready,
    output logic      o_d_bvalid,
    input  logic      i_d_bready
);

    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;
    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    logic    bvalid;
    logic    bready;

    logic [RAM_ADDR_BITS-1:0] rd_addr;
    data_t                    rd_data;
    logic                     we;
    logic [RAM_ADDR_BITS-1:0] wr_addr;
    data_t                    wr_data;
    strb_t                    wr_strb;

    axi_arbiter arb0 (
        .clk, .i_reset,
        .i_i_ar, .i_i_arvalid, .o_i_arready, .o_i_r, .o_i_rvalid, .i_i_rready,
        .i_d_ar, .i_d_arvalid, .o_d_arready, .o_d_r, .o_d_rvalid, .i_d_rready,
        .i_d_aw, .i_d_awvalid, .o_d_awready, .i_d_w, .i_d_wvalid, .o_d_wready,
        .o_d_bvalid, .i_d_bready,
        .o_ar(ar), .o_arvalid(arvalid), .i_arready(arready),
        .i_r(r), .i_rvalid(rvalid), .o_rready(rready),
        .o_aw(aw), .o_awvalid(awvalid), .i_awready(awready),
        .o_w(w), .o_wvalid(wvalid), .i_wready(wready),
        .i_bvalid(bvalid), .o_bready(bready)
    );

    axi_ram_read #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) rd0 (
        .clk, .i_reset,
        .i_ar(ar), .i_arvalid(arvalid), .o_arready(arready),
        .o_r(r), .o_rvalid(rvalid), .i_rready(rready),
        .o_rd_addr(rd_addr), .i_rd_data(rd_data)
    );

    axi_ram_write #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) wr0 (
        .clk, .i_reset,
        .i_aw(aw), .i_awvalid(awvalid), .o_awready(awready),
        .i_w(w), .i_wvalid(wvalid), .o_wready(wready),
        .o_bvalid(bvalid), .i_bready(bready),
        .o_we(we), .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_wr_strb(wr_strb)
    );

    ram_bank #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) ram0 (
        .clk,
        .i_rd_addr(rd_addr), .o_rd_data(rd_data),
        .i_we(we), .i_wr_addr(wr_addr), .i_wr_data(wr_data), .i_wr_strb(wr_strb)
    );

endmodule

//--- src/ram_bank.sv
`timescale 1ns/1ps

module ram_bank import cache_axi_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic                     clk,
    input  logic [RAM_ADDR_BITS-1:0] i_rd_addr,
    output data_t                    o_rd_data,
    input  logic                     i_we,
    input  logic [RAM_ADDR_BITS-1:0] i_wr_addr,
    input  data_t                    i_wr_data,
    input  strb_t                    i_wr_strb
);

    data_t mem [2**RAM_ADDR_BITS];

    assign o_rd_data = mem[i_rd_addr];

    // per-lane byte write
    always_ff @(posedge clk) begin
        if (i_we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_wr_strb[b]) begin
                    mem[i_wr_addr][8*b +: 8] <= i_wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- tb.f
src/cache_axi_pkg.sv
src/axi_arbiter.sv
src/ram_bank.sv
src/axi_ram_read.sv
src/axi_ram_write.sv
src/mem_subsys_top.sv
tests/tb_mem_subsys.sv

//--- tests/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys import cache_axi_pkg::*; ();

    localparam int RAM_ADDR_BITS = 8;
    localparam int MEM_WORDS     = 2**RAM_ADDR_BITS;
    // words filled before any read
    localparam int REGION        = 64;
    localparam int TIMEOUT       = 100;

    logic      clk;
    logic      reset;
    cache_ar_t ic_ar;
    logic      ic_arvalid;
    logic      ic_arready;
    cache_r_t  ic_r;
    logic      ic_rvalid;
    logic      ic_rready;
    cache_ar_t dc_ar;
    logic      dc_arvalid;
    logic      dc_arready;
    cache_r_t  dc_r;
    logic      dc_rvalid;
    logic      dc_rready;
    axi_aw_t   dc_aw;
    logic      dc_awvalid;
    logic      dc_awready;
    axi_w_t    dc_w;
    logic      dc_wvalid;
    logic      dc_wready;
    logic      dc_bvalid;
    logic      dc_bready;

    data_t model [MEM_WORDS];
    // set while a burst is expected on that port
    logic  ic_busy;
    logic  dc_busy;

    mem_subsys_top #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) dut0 (
        .clk, .i_reset(reset),
        .i_i_ar(ic_ar), .i_i_arvalid(ic_arvalid), .o_i_arready(ic_arready),
        .o_i_r(ic_r), .o_i_rvalid(ic_rvalid), .i_i_rready(ic_rready),
        .i_d_ar(dc_ar), .i_d_arvalid(dc_arvalid), .o_d_arready(dc_arready),
        .o_d_r(dc_r), .o_d_rvalid(dc_rvalid), .i_d_rready(dc_rready),
        .i_d_aw(dc_aw), .i_d_awvalid(dc_awvalid), .o_d_awready(dc_awready),
        .i_d_w(dc_w), .i_d_wvalid(dc_wvalid), .o_d_wready(dc_wready),
        .o_d_bvalid(dc_bvalid), .i_d_bready(dc_bready)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_rbeat(input cache_r_t got, input cache_r_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got data %h last %b, expected data %h last %b",
                     $time, what, got.data, got.last, exp.data, exp.last);
            abort_run();
        end
    endtask

    task automatic check_bresp(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s bvalid is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // nothing may show up on a port that has no burst pending
    always @(posedge clk) begin
        if (!reset) begin
            if (ic_rvalid !== 1'b0 && !ic_busy) begin
                report_error("read beat on instruction port with no read pending");
            end
            if (dc_rvalid !== 1'b0 && !dc_busy) begin
                report_error("read beat on data port with no read pending");
            end
        end
    end

    // upper address bits above the RAM size must be ignored
    function automatic addr_t byte_addr(input int word);
        return addr_t'(word * 4 + MEM_WORDS * 4 * $urandom_range(0, 7));
    endfunction

    task automatic write_burst(input int start, input int nbeats, input bit full);
        int t;
        int idx;
        int hold;
        @(negedge clk);
        dc_aw = '{addr: byte_addr(start), len: len_t'(nbeats - 1)};
        dc_awvalid = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) report_error("write address was never accepted");
        end while (dc_awready !== 1'b1);
        check_bresp(dc_bvalid, 1'b0, "response before write data");
        for (int k = 0; k < nbeats; k++) begin
            @(negedge clk);
            dc_awvalid = 1'b0;
            dc_w = '{data: data_t'($urandom), strb: full ? 4'hf : strb_t'($urandom),
                     last: (k == nbeats - 1)};
            dc_wvalid = 1'b1;
            t = 0;
            do begin
                @(posedge clk);
                t++;
                if (t > TIMEOUT) report_error("write beat was never accepted");
            end while (dc_wready !== 1'b1);
            idx = (start + k) % MEM_WORDS;
            for (int b = 0; b < 4; b++) begin
                if (dc_w.strb[b]) model[idx][8*b +: 8] = dc_w.data[8*b +: 8];
            end
        end
        @(negedge clk);
        dc_wvalid = 1'b0;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) report_error("no write response after the last beat");
        end while (dc_bvalid !== 1'b1);
        hold = $urandom_range(0, 3);
        repeat (hold) begin
            @(posedge clk);
            check_bresp(dc_bvalid, 1'b1, "response dropped before bready");
        end
        @(negedge clk);
        dc_bready = 1'b1;
        @(posedge clk);
        check_bresp(dc_bvalid, 1'b1, "response at bready");
        @(negedge clk);
        dc_bready = 1'b0;
        @(posedge clk);
        check_bresp(dc_bvalid, 1'b0, "response after it was taken");
    endtask

    task automatic read_burst(input bit is_inst, input int start, input int nbeats,
                              input bit after_inst);
        cache_ar_t req;
        cache_r_t  got;
        cache_r_t  exp;
        logic      rv;
        logic      rr;
        int        k;
        int        t;
        req = '{addr: byte_addr(start), len: len_t'(nbeats - 1)};
        @(negedge clk);
        if (is_inst) begin
            ic_busy    = 1'b1;
            ic_ar      = req;
            ic_arvalid = 1'b1;
        end else begin
            dc_busy    = 1'b1;
            dc_ar      = req;
            dc_arvalid = 1'b1;
        end
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) report_error("read address was never accepted");
            // the other burst owns the engine until this address is taken
            if ((is_inst ? ic_rvalid : dc_rvalid) === 1'b1) begin
                report_error("read beat on a port whose address is still waiting");
            end
        end while ((is_inst ? ic_arready : dc_arready) !== 1'b1);
        @(negedge clk);
        if (is_inst) ic_arvalid = 1'b0;
        else dc_arvalid = 1'b0;
        k = 0;
        t = 0;
        while (k < nbeats) begin
            rr = ($urandom_range(0, 3) != 0);
            if (is_inst) ic_rready = rr;
            else dc_rready = rr;
            @(posedge clk);
            rv  = is_inst ? ic_rvalid : dc_rvalid;
            got = is_inst ? ic_r : dc_r;
            if (rv === 1'b1) begin
                if (after_inst && ic_busy) begin
                    report_error("data beat arrived before the instruction burst finished");
                end
                exp = '{data: model[(start + k) % MEM_WORDS], last: (k == nbeats - 1)};
                check_rbeat(got, exp, is_inst ? "instruction read" : "data read");
                if (rr) begin
                    k++;
                    t = 0;
                end
            end
            t++;
            if (t > TIMEOUT) report_error("read beat never arrived");
            @(negedge clk);
        end
        if (is_inst) begin
            ic_rready = 1'b0;
            ic_busy   = 1'b0;
        end else begin
            dc_rready = 1'b0;
            dc_busy   = 1'b0;
        end
    endtask

    initial begin
        int w;
        int n;
        int n2;
        int s;
        int s2;
        void'($urandom(63171));
        clk        = 1'b0;
        reset      = 1'b1;
        ic_ar      = '0;
        ic_arvalid = 1'b0;
        ic_rready  = 1'b0;
        dc_ar      = '0;
        dc_arvalid = 1'b0;
        dc_rready  = 1'b0;
        dc_aw      = '0;
        dc_awvalid = 1'b0;
        dc_w       = '0;
        dc_wvalid  = 1'b0;
        dc_bready  = 1'b0;
        ic_busy    = 1'b0;
        dc_busy    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        check_bresp(dc_bvalid, 1'b0, "after reset");
        if (dc_wready !== 1'b0) report_error("wready is high after reset");
        // fill the region with full-word bursts
        w = 0;
        while (w < REGION) begin
            n = $urandom_range(1, 8);
            if (w + n > REGION) n = REGION - w;
            write_burst(w, n, 1'b1);
            w += n;
        end
        repeat (20) begin
            n = $urandom_range(1, 8);
            read_burst(1'b0, $urandom_range(0, REGION - n), n, 1'b0);
        end
        // partial strobes merged into the model
        repeat (20) begin
            n = $urandom_range(1, 8);
            write_burst($urandom_range(0, REGION - n), n, 1'b0);
            n = $urandom_range(1, 8);
            read_burst(1'b0, $urandom_range(0, REGION - n), n, 1'b0);
        end
        // both caches request on the same edge
        repeat (10) begin
            n  = $urandom_range(1, 8);
            n2 = $urandom_range(1, 8);
            s  = $urandom_range(0, REGION - n);
            s2 = $urandom_range(0, REGION - n2);
            fork
                read_burst(1'b1, s, n, 1'b0);
                read_burst(1'b0, s2, n2, 1'b1);
            join
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule
